// ==== all.f ====
verilog/calc_pkg.sv
verilog/keypad_scanner.sv
verilog/calc_controller.sv
verilog/operand_entry.sv
verilog/calc_alu.sv
verilog/wb_calc_regs.sv
verilog/keypad_calc_top.sv
test/keypad_calc_asserts.sv
test/keypad_calc_tb.sv

// ==== test/keypad_calc_asserts.sv ====
`default_nettype none

module keypad_calc_asserts
    import calc_pkg::*;
(
    input wire logic       clk,
    input wire logic       nRST,
    input wire logic [3:0] col_out,     // scanner column drive
    input wire logic       key_rdy,
    input wire key_event_t key_evt,
    input wire logic       cyc,         // wishbone side
    input wire logic       stb,
    input wire logic       ack
);

    timeunit 1ns;
    timeprecision 100ps;

    // event must not move under a waiting controller
    evt_stable: assert property (@(posedge clk) disable iff (!nRST)
        key_rdy && $past(key_rdy) |-> $stable(key_evt))
        else $error("key_evt changed while key_rdy was high");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!nRST) ack |=> !ack)
        else $error("ack held high for more than one cycle");

    ack_after_req: assert property (@(posedge clk) disable iff (!nRST)
        ack |-> $past(cyc && stb))
        else $error("ack without a preceding cyc and stb");

    // column stays parked while an event waits, so the release is seen
    col_parked: assert property (@(posedge clk) disable iff (!nRST)
        key_rdy |-> $stable(col_out))
        else $error("col_out moved while key_rdy was high");

endmodule

// scanner side, wishbone inputs tied idle
bind keypad_scanner keypad_calc_asserts u_scan_asserts (
    .clk, .nRST, .col_out, .key_rdy, .key_evt, .cyc(1'b0), .stb(1'b0), .ack(1'b0)
);

// wishbone side, scanner inputs tied to a legal idle value
bind wb_calc_regs keypad_calc_asserts u_wb_asserts (
    .clk, .nRST, .col_out(4'b1110), .key_rdy(1'b0), .key_evt('0), .cyc, .stb, .ack
);

`default_nettype wire

// ==== test/keypad_calc_tb.sv ====
`default_nettype none

module keypad_calc_tb
    import calc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;    // ns
    localparam int RESET_CYCLES = 16;
    localparam int HOLD         = 60;   // normal press length, cycles
    localparam int RELEASE      = 40;   // idle after release
    localparam int ACK_WAIT     = 8;    // bound on wishbone ack
    localparam int NUM_TESTS    = 9;

    typedef struct packed {
        logic [63:0]       keys;        // up to 8 chars, right aligned, 0 = unused
        logic [15:0]       hold;        // cycles each key is held
        logic              clr;         // host clear before the keys
        logic [DATA_W-1:0] res;         // expected result register
        logic [DATA_W-1:0] ent;         // expected entry register
        logic              ovf;
        logic [7:0]        cnt;         // expected evaluation count
    } test_row_t;

    logic              clk;
    logic              nRST;
    logic [3:0]        row_in;
    logic [3:0]        col_out;
    logic              cyc, stb, we;
    logic [1:0]        adr;
    logic [DATA_W-1:0] dat_w, dat_r, rd_data;
    logic              ack;
    logic              key_down;        // keypad model state
    logic [1:0]        key_row, key_col;

    // state carries over from row to row
    test_row_t tests [NUM_TESTS] = '{
        '{"123",      16'(HOLD), 1'b0, 16'd0,       16'd123,   1'b0, 8'd0},
        '{"D",        16'(HOLD), 1'b0, 16'd0,       16'(-123), 1'b0, 8'd0},
        '{"12A30*",   16'(HOLD), 1'b1, 16'd42,      16'd0,     1'b0, 8'd1},
        '{"5B9*",     16'(HOLD), 1'b0, 16'(-4),     16'd0,     1'b0, 8'd2},
        '{"7C6*",     16'(HOLD), 1'b0, 16'd42,      16'd0,     1'b0, 8'd3},
        '{"300C300*", 16'(HOLD), 1'b0, 16'(300*300), 16'd0,    1'b1, 8'd4},  // wraps
        '{"1A1*",     16'(HOLD), 1'b0, 16'd2,       16'd0,     1'b0, 8'd5},
        '{"4",        16'd300,   1'b1, 16'd2,       16'd4,     1'b0, 8'd0},  // count cleared, long hold
        '{"#",        16'(HOLD), 1'b0, 16'd2,       16'd4,     1'b0, 8'd0}
    };

    keypad_calc_top dut (
        .clk, .nRST, .row_in, .col_out, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // pressed key shorts its row to its column
    assign row_in = (key_down && !col_out[key_col]) ? ~(4'b0001 << key_row) : 4'hF;

    function automatic logic [4:0] key_place(input byte c);  // {known, row, col}
        case (c)
            "1": return 5'b1_00_00;
            "2": return 5'b1_00_01;
            "3": return 5'b1_00_10;
            "A": return 5'b1_00_11;
            "4": return 5'b1_01_00;
            "5": return 5'b1_01_01;
            "6": return 5'b1_01_10;
            "B": return 5'b1_01_11;
            "7": return 5'b1_10_00;
            "8": return 5'b1_10_01;
            "9": return 5'b1_10_10;
            "C": return 5'b1_10_11;
            "*": return 5'b1_11_00;
            "0": return 5'b1_11_01;
            "#": return 5'b1_11_10;
            "D": return 5'b1_11_11;
            default: return 5'b0_00_00;
        endcase
    endfunction

    function automatic int count_keys(input logic [63:0] keys);
        int n;
        n = 0;
        for (int k = 0; k < 8; k++) begin
            if (keys[8*k +: 8] != 8'h00) n++;
        end
        return n;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) fail_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic press_key(input byte c, input int hold);
        logic [4:0] place;
        place = key_place(c);
        if (!place[4]) fail_run($sformatf("key %c is not on the keypad", c));
        @(negedge clk);
        key_row  = place[3:2];
        key_col  = place[1:0];
        key_down = 1'b1;
        repeat (hold) @(negedge clk);
        key_down = 1'b0;
        repeat (RELEASE) @(negedge clk);                 // let scanner see release
    endtask

    task automatic wb_access(input logic write, input logic [1:0] addr,
                             input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
        int waited;
        @(negedge clk);
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = write;
        adr    = addr;
        dat_w  = wdata;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_WAIT) fail_run("no Wishbone ack arrived within the wait limit");
        end while (!ack);
        check("ack_latency", waited, 1);
        rdata = dat_r;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        @(negedge clk);
        check("ack", ack, 0);                            // single cycle ack
    endtask

    task automatic check_regs(input test_row_t t);
        wb_access(1'b0, REG_RESULT, '0, rd_data);
        check("result", rd_data, t.res);
        wb_access(1'b0, REG_ENTRY, '0, rd_data);
        check("entry", rd_data, t.ent);
        wb_access(1'b0, REG_STATUS, '0, rd_data);
        check("status", rd_data, (32'(t.ovf) << STATUS_OVF_BIT) | 32'(t.cnt));
    endtask

    initial begin
        test_row_t t;
        clk      = 1'b0;
        nRST     = 1'b0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        dat_w    = '0;
        key_down = 1'b0;
        key_row  = '0;
        key_col  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        nRST = 1'b1;
        check("ack", ack, 0);
        check("col_out", col_out, 4'b1110);              // column 0 first
        for (int a = 0; a < 4; a++) begin
            wb_access(1'b0, 2'(a), '0, rd_data);
            check("reset_reg", rd_data, 0);
        end
        foreach (tests[i]) begin
            t = tests[i];
            if (t.clr) begin                             // ctrl bit 0 clears entry and count
                wb_access(1'b1, REG_CTRL, 16'h0001, rd_data);
                wb_access(1'b0, REG_ENTRY, '0, rd_data);
                check("entry_after_clear", rd_data, 0);
                wb_access(1'b0, REG_STATUS, '0, rd_data);
                check("count_after_clear", rd_data[7:0], 0);
            end
            for (int k = 7; k >= 0; k--) begin
                if (t.keys[8*k +: 8] != 8'h00) press_key(t.keys[8*k +: 8], t.hold);
            end
            check_regs(t);
        end
        $display("Simulation completed successfully");
        $finish;
    end

    // budget is every key press plus release, then a margin for reset and reads
    initial begin
        int budget;
        budget = 0;
        foreach (tests[i]) budget += count_keys(tests[i].keys) * (tests[i].hold + RELEASE);
        budget += 2000;
        #(budget * CLK_PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

// ==== verilog/calc_alu.sv ====
`default_nettype none

module calc_alu
    import calc_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              nRST,
    input  wire logic              eval,        // one-cycle evaluate strobe
    input  wire calc_op_t          op,
    input  wire logic [DATA_W-1:0] operand_a,
    input  wire logic [DATA_W-1:0] operand_b,   // the current entry
    output logic      [DATA_W-1:0] result,
    output logic                   ovf
);

    logic        [DATA_W-1:0]   sum;
    logic        [DATA_W-1:0]   diff;
    logic signed [2*DATA_W-1:0] prod;           // full signed product
    logic        [DATA_W-1:0]   res_nxt;
    logic                       ovf_nxt;

    always_comb begin
        sum  = operand_a + operand_b;
        diff = operand_a - operand_b;
        prod = $signed(operand_a) * $signed(operand_b);
        case (op)
            OP_ADD: begin                                   // same signs in, sign flips
                res_nxt = sum;
                ovf_nxt = (operand_a[DATA_W-1] == operand_b[DATA_W-1]) &&
                          (sum[DATA_W-1] != operand_a[DATA_W-1]);
            end
            OP_SUB: begin                                   // signs differ, sign flips
                res_nxt = diff;
                ovf_nxt = (operand_a[DATA_W-1] != operand_b[DATA_W-1]) &&
                          (diff[DATA_W-1] != operand_a[DATA_W-1]);
            end
            OP_MUL: begin                                   // high half not sign ext
                res_nxt = prod[DATA_W-1:0];
                ovf_nxt = prod[2*DATA_W-1:DATA_W] != {DATA_W{prod[DATA_W-1]}};
            end
            default: begin
                res_nxt = '0;
                ovf_nxt = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            result <= '0;
            ovf    <= 1'b0;
        end else if (eval) begin
            result <= res_nxt;
            ovf    <= ovf_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/calc_controller.sv ====
`default_nettype none

module calc_controller
    import calc_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              nRST,
    input  wire logic              key_rdy,
    input  wire key_event_t        key_evt,
    output logic                   key_rd,      // one-cycle read pulse
    input  wire logic              host_clear,
    input  wire logic [DATA_W-1:0] entry,       // current entry value
    output entry_cmd_t             entry_cmd,
    output logic      [DATA_W-1:0] operand_a,
    output calc_op_t               op,
    output logic                   eval,
    output logic      [COUNT_W-1:0] eval_count
);

    typedef enum logic [1:0] {
        ENTER_A, ENTER_B, WAIT_KEY
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t ret_state;                     // where to go once key released

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= ENTER_A;
            ret_state  <= ENTER_A;
            key_rd     <= 1'b0;
            entry_cmd  <= '0;
            operand_a  <= '0;
            op         <= OP_ADD;
            eval       <= 1'b0;
            eval_count <= '0;
        end else begin
            key_rd    <= 1'b0;                  // pulses default low
            entry_cmd <= '0;
            eval      <= 1'b0;
            if (host_clear) begin
                entry_cmd.clear <= 1'b1;
                operand_a       <= '0;
                eval_count      <= '0;
                ret_state       <= ENTER_A;
                if (state != WAIT_KEY) state <= ENTER_A;  // still let held key drain
            end else begin
                case (state)
                    ENTER_A, ENTER_B: begin
                        if (key_rdy) begin
                            key_rd    <= 1'b1;
                            state     <= WAIT_KEY;
                            ret_state <= state;
                            case (key_evt.kind)
                                KEY_DIGIT: begin
                                    entry_cmd.load_digit <= 1'b1;
                                    entry_cmd.digit      <= key_evt.digit;
                                end
                                KEY_NEG: entry_cmd.negate <= 1'b1;
                                KEY_OP: begin               // latch A, start B
                                    operand_a       <= entry;
                                    op              <= key_evt.op;
                                    entry_cmd.clear <= 1'b1;
                                    ret_state       <= ENTER_B;
                                end
                                KEY_EQUAL: begin
                                    if (state == ENTER_B) begin  // no pending op in A
                                        eval            <= 1'b1;
                                        entry_cmd.clear <= 1'b1;
                                        eval_count      <= eval_count + 1'b1;
                                        ret_state       <= ENTER_A;
                                    end
                                end
                                default: ;                  // KEY_NONE, just consume
                            endcase
                        end
                    end
                    WAIT_KEY: if (!key_rdy) state <= ret_state;
                    default:  state <= ENTER_A;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/calc_pkg.sv ====
`default_nettype none

package calc_pkg;

    localparam int DATA_W          = 16;                       // operand / result / entry width
    localparam int COUNT_W         = 8;                        // evaluation counter width
    localparam int DEBOUNCE_CYCLES = 10;                       // pressed samples to confirm
    localparam int DEBOUNCE_W      = $clog2(DEBOUNCE_CYCLES);  // debounce counter width

    // decoded key classes
    typedef enum logic [2:0] {
        KEY_NONE, KEY_DIGIT, KEY_OP, KEY_NEG, KEY_EQUAL
    } key_kind_t;

    typedef enum logic [1:0] {
        OP_ADD, OP_SUB, OP_MUL                                 // keys A, B, C
    } calc_op_t;

    typedef struct packed {
        key_kind_t  kind;
        logic [3:0] digit;                                     // 0..9, only for KEY_DIGIT
        calc_op_t   op;                                        // only for KEY_OP
    } key_event_t;

    typedef struct packed {
        logic       clear;
        logic       load_digit;
        logic       negate;
        logic [3:0] digit;
    } entry_cmd_t;

    // wishbone word addresses
    localparam logic [1:0] REG_RESULT = 2'd0;
    localparam logic [1:0] REG_ENTRY  = 2'd1;
    localparam logic [1:0] REG_STATUS = 2'd2;
    localparam logic [1:0] REG_CTRL   = 2'd3;

    localparam int STATUS_OVF_BIT = 8;                         // above the 8-bit eval count

endpackage

`default_nettype wire

// ==== verilog/keypad_calc_top.sv ====
`default_nettype none

module keypad_calc_top
    import calc_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              nRST,
    input  wire logic [3:0]        row_in,     // keypad rows
    output logic      [3:0]        col_out,    // keypad columns
    input  wire logic              cyc,        // wishbone slave
    input  wire logic              stb,
    input  wire logic              we,
    input  wire logic [1:0]        adr,
    input  wire logic [DATA_W-1:0] dat_w,
    output logic      [DATA_W-1:0] dat_r,
    output logic                   ack
);

    logic               key_rdy;
    logic               key_rd;
    key_event_t         key_evt;
    logic               host_clear;
    entry_cmd_t         entry_cmd;
    logic [DATA_W-1:0]  entry;
    logic [DATA_W-1:0]  operand_a;
    calc_op_t           op;
    logic               eval;
    logic [COUNT_W-1:0] eval_count;
    logic [DATA_W-1:0]  result;
    logic               ovf;

    keypad_scanner u_scanner (
        .clk, .nRST, .row_in, .col_out, .key_rdy, .key_rd, .key_evt
    );

    calc_controller u_ctrl (
        .clk, .nRST, .key_rdy, .key_evt, .key_rd, .host_clear,
        .entry, .entry_cmd, .operand_a, .op, .eval, .eval_count
    );

    operand_entry u_entry (
        .clk, .nRST, .entry_cmd, .entry
    );

    calc_alu u_alu (                            // operand b is the live entry
        .clk, .nRST, .eval, .op, .operand_a, .operand_b(entry), .result, .ovf
    );

    wb_calc_regs u_regs (
        .clk, .nRST, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
        .result, .entry, .ovf, .eval_count, .host_clear
    );

endmodule

`default_nettype wire

// ==== verilog/keypad_scanner.sv ====
`default_nettype none

module keypad_scanner
    import calc_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       nRST,
    input  wire logic [3:0] row_in,     // rows, pulled up, low when pressed
    output logic      [3:0] col_out,    // one column driven low at a time
    output logic            key_rdy,    // event waiting for controller
    input  wire logic       key_rd,     // controller took the event
    output key_event_t      key_evt
);

    typedef enum logic [1:0] {
        S_SCAN, S_DEBOUNCE, S_HOLD, S_RELEASE
    } scan_state_t;

    scan_state_t           state;
    logic [1:0]            col_idx;     // active column
    logic [DEBOUNCE_W-1:0] deb_cnt;     // consecutive pressed samples
    logic [3:0]            key_code;    // row*4 + col
    logic                  key_valid;   // any row low

    // lowest pressed row wins
    function automatic logic [3:0] encode_key(input logic [3:0] row, input logic [1:0] col);
        logic [3:0] code;
        code = 4'hF;
        for (int r = 3; r >= 0; r--) begin
            if (!row[r]) code = {2'(r), col};
        end
        return code;
    endfunction

    assign key_valid = ~&row_in;
    assign col_out   = ~(4'b0001 << col_idx);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state    <= S_SCAN;
            col_idx  <= 2'd0;
            deb_cnt  <= '0;
            key_code <= 4'h0;
            key_rdy  <= 1'b0;
        end else begin
            case (state)
                S_SCAN: begin
                    if (key_valid) begin                   // park on this column
                        deb_cnt <= DEBOUNCE_W'(1);
                        state   <= S_DEBOUNCE;
                    end else begin
                        col_idx <= col_idx + 2'd1;
                    end
                end
                S_DEBOUNCE: begin
                    if (!key_valid) begin                  // bounce, back to scanning
                        deb_cnt <= '0;
                        state   <= S_SCAN;
                    end else if (deb_cnt == DEBOUNCE_W'(DEBOUNCE_CYCLES - 1)) begin
                        key_code <= encode_key(row_in, col_idx);
                        key_rdy  <= 1'b1;
                        state    <= S_HOLD;
                    end else begin
                        deb_cnt <= deb_cnt + 1'b1;
                    end
                end
                S_HOLD:    if (key_rd) state <= S_RELEASE;  // wait for read
                S_RELEASE: begin
                    if (!key_valid) begin                  // key let go
                        key_rdy <= 1'b0;
                        state   <= S_SCAN;
                    end
                end
                default:   state <= S_SCAN;
            endcase
        end
    end

    // key map, code = row*4 + col
    always_comb begin
        key_evt = '{kind: KEY_NONE, digit: 4'd0, op: OP_ADD};
        case (key_code)
            4'h0: key_evt = '{kind: KEY_DIGIT, digit: 4'd1, op: OP_ADD};
            4'h1: key_evt = '{kind: KEY_DIGIT, digit: 4'd2, op: OP_ADD};
            4'h2: key_evt = '{kind: KEY_DIGIT, digit: 4'd3, op: OP_ADD};
            4'h3: key_evt = '{kind: KEY_OP,    digit: 4'd0, op: OP_ADD};  // A
            4'h4: key_evt = '{kind: KEY_DIGIT, digit: 4'd4, op: OP_ADD};
            4'h5: key_evt = '{kind: KEY_DIGIT, digit: 4'd5, op: OP_ADD};
            4'h6: key_evt = '{kind: KEY_DIGIT, digit: 4'd6, op: OP_ADD};
            4'h7: key_evt = '{kind: KEY_OP,    digit: 4'd0, op: OP_SUB};  // B
            4'h8: key_evt = '{kind: KEY_DIGIT, digit: 4'd7, op: OP_ADD};
            4'h9: key_evt = '{kind: KEY_DIGIT, digit: 4'd8, op: OP_ADD};
            4'hA: key_evt = '{kind: KEY_DIGIT, digit: 4'd9, op: OP_ADD};
            4'hB: key_evt = '{kind: KEY_OP,    digit: 4'd0, op: OP_MUL};  // C
            4'hC: key_evt = '{kind: KEY_EQUAL, digit: 4'd0, op: OP_ADD};  // *
            4'hD: key_evt = '{kind: KEY_DIGIT, digit: 4'd0, op: OP_ADD};
            4'hF: key_evt = '{kind: KEY_NEG,   digit: 4'd0, op: OP_ADD};  // D
            default: ;                                                    // # ignored
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/operand_entry.sv ====
`default_nettype none

module operand_entry
    import calc_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              nRST,
    input  wire entry_cmd_t        entry_cmd,
    output logic      [DATA_W-1:0] entry       // decimal entry, two's complement
);

    logic [DATA_W-1:0] times_ten;              // entry*10, wraps
    logic [DATA_W-1:0] with_digit;             // entry*10 + digit
    logic [DATA_W-1:0] negated;

    // x*10 = x*8 + x*2
    always_comb begin
        times_ten  = (entry << 3) + (entry << 1);
        with_digit = times_ten + DATA_W'(entry_cmd.digit);
        negated    = '0 - entry;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            entry <= '0;
        end else if (entry_cmd.clear) begin            // clear wins
            entry <= '0;
        end else if (entry_cmd.negate) begin
            entry <= negated;
        end else if (entry_cmd.load_digit) begin
            entry <= with_digit;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/wb_calc_regs.sv ====
`default_nettype none

module wb_calc_regs
    import calc_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               nRST,
    input  wire logic               cyc,
    input  wire logic               stb,
    input  wire logic               we,
    input  wire logic [1:0]         adr,          // word address
    input  wire logic [DATA_W-1:0]  dat_w,
    output logic      [DATA_W-1:0]  dat_r,
    output logic                    ack,
    input  wire logic [DATA_W-1:0]  result,
    input  wire logic [DATA_W-1:0]  entry,
    input  wire logic               ovf,
    input  wire logic [COUNT_W-1:0] eval_count,
    output logic                    host_clear    // one-cycle clear to controller
);

    logic              req;                       // new request, not yet acked
    logic [DATA_W-1:0] status;

    assign req = cyc & stb & ~ack;                // forces a low cycle between acks

    always_comb begin
        status                 = '0;
        status[COUNT_W-1:0]    = eval_count;
        status[STATUS_OVF_BIT] = ovf;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            ack        <= 1'b0;
            dat_r      <= '0;
            host_clear <= 1'b0;
        end else begin
            ack        <= req;
            host_clear <= req & we & (adr == REG_CTRL) & dat_w[0];
            if (req & ~we) begin
                case (adr)
                    REG_RESULT: dat_r <= result;
                    REG_ENTRY:  dat_r <= entry;
                    REG_STATUS: dat_r <= status;
                    default:    dat_r <= '0;      // ctrl is write only
                endcase
            end
        end
    end

endmodule

`default_nettype wire
